// ==== dv/tb_gm_controller.sv ====
// Packet hub testbench
`timescale 1ns/1ps

module tb_gm_controller;

	localparam int ROUND_CYCLES = 200;
	localparam int NUM_PLAYERS  = 2;
	localparam int READ_WORDS   = gm_pkg::BUF_WORDS - gm_pkg::RX_BASE;
	localparam int WB_WORDS     = NUM_PLAYERS * gm_pkg::SLOT_WORDS;
	localparam int TX_WORDS     = NUM_PLAYERS * (gm_pkg::SLOT_WORDS + 1);
	localparam int TIMEOUT      = 5000;          // Cycles per wait
	localparam int NUM_TESTS    = 6;
	localparam int T_RESET      = 0;
	localparam int T_RX         = 1;
	localparam int T_IRQ        = 2;
	localparam int T_WB         = 3;
	localparam int T_BP         = 4;
	localparam int T_HOLD       = 5;

	logic              system_clk;
	logic              rst_n;
	logic              round_enable;
	logic              rx_fifo_empty;
	gm_pkg::word_t     rx_fifo_rd_data;
	logic              rx_fifo_rd_req;
	logic              tx_fifo_full;
	logic              tx_fifo_wr_req;
	gm_pkg::word_t     tx_fifo_wr_data;
	logic              proc_irq;
	gm_pkg::proc_in_t  proc_in;
	gm_pkg::proc_out_t proc_out;

	gm_pkg::word_t model [gm_pkg::BUF_WORDS];    // Expected buffer contents
	gm_pkg::word_t rd_snap [READ_WORDS];         // Read-out expected this round
	gm_pkg::word_t rx_q [$];                     // Receive FIFO contents
	gm_pkg::word_t tx_cap [$];                   // Words written to transmit FIFO
	logic [31:0]   rng_data;
	logic [31:0]   rng_full;
	logic          rx_pop;
	int            irq_count;
	int            full_writes;                  // Writes seen while full
	int            test_err [NUM_TESTS];

	gm_controller #(
		.ROUND_CYCLES (ROUND_CYCLES),
		.NUM_PLAYERS  (NUM_PLAYERS)
	) DUT (
		.system_clk      (system_clk),
		.rst_n           (rst_n),
		.round_enable    (round_enable),
		.rx_fifo_empty   (rx_fifo_empty),
		.rx_fifo_rd_data (rx_fifo_rd_data),
		.rx_fifo_rd_req  (rx_fifo_rd_req),
		.tx_fifo_full    (tx_fifo_full),
		.tx_fifo_wr_req  (tx_fifo_wr_req),
		.tx_fifo_wr_data (tx_fifo_wr_data),
		.proc_irq        (proc_irq),
		.proc_in         (proc_in),
		.proc_out        (proc_out)
	);

	always #10 system_clk = ~system_clk;        // 20 ns period

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic gm_pkg::word_t next_word();
		rng_data = xorshift32(rng_data);
		return rng_data[15:0];
	endfunction

	// Payload word i of a slot lands here
	function automatic int rx_addr(input int slot, input int i);
		return gm_pkg::RX_BASE + slot * gm_pkg::SLOT_WORDS + i;
	endfunction

	// Slot in bits 1:0, payload count in 14:8
	function automatic gm_pkg::word_t make_header(input int slot, input int count);
		return gm_pkg::word_t'((count << 8) | slot);
	endfunction

	// Expected transmit word, index 0 is the header
	function automatic gm_pkg::word_t tx_word(input int player, input int idx);
		if (idx == 0)
			return gm_pkg::word_t'(player + 1);
		return model[player * gm_pkg::SLOT_WORDS + idx - 1];
	endfunction

	function automatic string name_of(input int t);
		case (t)
			T_RESET: return "reset";
			T_RX:    return "receive_storage";
			T_IRQ:   return "interrupt";
			T_WB:    return "writeback_transmit";
			T_BP:    return "backpressure";
			default: return "hold_during_round";
		endcase
	endfunction

	function automatic logic probe(input int sel);
		case (sel)
			0:       return proc_in.request;
			1:       return proc_in.data_valid;
			default: return rx_fifo_empty;
		endcase
	endfunction

	task automatic report_mismatch(input int t, input string what,
		input gm_pkg::word_t exp, input gm_pkg::word_t act);
		test_err[t]++;
		$display("CHECK FAILED %s %s expected %h actual %h", name_of(t), what, exp, act);
	endtask

	task automatic report_error(input int t, input string what);
		test_err[t]++;
		$display("ERROR in %s: %s", name_of(t), what);
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Testbench failed");
		$finish;
	endtask

	task automatic end_test(input int t);
		$display("Test %s finished with %0d errors", name_of(t), test_err[t]);
	endtask

	// Returns just after the edge where the level is seen
	task automatic wait_level(input int sel, input logic level, input string what);
		int n;
		n = 0;
		@(posedge system_clk);
		while (probe(sel) !== level && n < TIMEOUT)
		begin
			@(posedge system_clk);
			n++;
		end
		if (probe(sel) !== level)
			timeout_fail(what);
	endtask

	task automatic push_packet(input int slot);
		gm_pkg::word_t w;
		rx_q.push_back(make_header(slot, gm_pkg::SLOT_WORDS));
		for (int i = 0; i < gm_pkg::SLOT_WORDS; i++)
		begin
			w = next_word();
			model[rx_addr(slot, i)] = w;
			rx_q.push_back(w);
		end
	endtask

	// Processor side of one round
	task automatic run_round(input int round, input bit inject);
		int            n;
		int            t_rd;
		gm_pkg::word_t got;
		gm_pkg::word_t wb;
		t_rd = (round == 1) ? T_RX : T_HOLD;
		for (int a = 0; a < READ_WORDS; a++)
			rd_snap[a] = model[gm_pkg::RX_BASE + a];  // Before any new packet
		n = 0;
		@(posedge system_clk);
		while (!proc_irq && n < TIMEOUT)
		begin
			if (proc_in.request)
				report_error(T_IRQ, "request high before proc_irq");
			@(posedge system_clk);
			n++;
		end
		if (!proc_irq)
			timeout_fail("proc_irq");
		if (proc_in.request)
			report_error(T_IRQ, "request high during proc_irq");
		wait_level(0, 1'b1, "request high");
		#2 proc_out.rdy_read = 1'b1;
		wait_level(0, 1'b0, "request low");
		#2 proc_out.rdy_read = 1'b0;
		for (int i = 0; i < READ_WORDS; i++)
		begin
			wait_level(1, 1'b1, "data_valid high");
			got = proc_in.data;
			if (got !== rd_snap[i])
				report_mismatch(t_rd, $sformatf("read-out word %0d", i), rd_snap[i], got);
			#2 proc_out.ack = 1'b1;
			if (inject && i == 64)
				push_packet(2);              // Arrives mid read phase
			wait_level(1, 1'b0, "data_valid low");
			#2 proc_out.ack = 1'b0;
		end
		for (int k = 0; k < WB_WORDS; k++)
		begin
			wb = next_word();
			model[k] = wb;
			proc_out.data       = wb;
			proc_out.data_ready = 1'b1;      // One cycle strobe
			@(posedge system_clk);
			#2 proc_out.data_ready = 1'b0;
			repeat (4) @(posedge system_clk);  // Processor pacing
			#2;
		end
		proc_out.done = 1'b1;
		@(posedge system_clk);
		#2 proc_out.done = 1'b0;
		// Round still holds the buffer, whole packet must wait in the FIFO
		if (inject && rx_q.size() != gm_pkg::SLOT_WORDS + 1)
			report_error(T_HOLD, "receive FIFO was read while the round held the buffer");
	endtask

	task automatic check_transmit(input int t);
		int            n;
		int            idx;
		gm_pkg::word_t exp;
		n = 0;
		@(posedge system_clk);
		#1;
		while (tx_cap.size() < TX_WORDS && n < TIMEOUT)
		begin
			@(posedge system_clk);
			#1;
			n++;
		end
		if (tx_cap.size() < TX_WORDS)
			timeout_fail("transmit FIFO words");
		repeat (20) @(posedge system_clk);     // Quiet window for extra words
		#1;
		if (tx_cap.size() != TX_WORDS)
			report_error(t, $sformatf("transmit FIFO got %0d words, not %0d",
				tx_cap.size(), TX_WORDS));
		for (int p = 0; p < NUM_PLAYERS; p++)
		begin
			for (int k = 0; k <= gm_pkg::SLOT_WORDS; k++)
			begin
				idx = p * (gm_pkg::SLOT_WORDS + 1) + k;
				exp = tx_word(p, k);
				if (idx < tx_cap.size() && tx_cap[idx] !== exp)
					report_mismatch(t, $sformatf("player %0d word %0d", p, k), exp, tx_cap[idx]);
			end
		end
		tx_cap.delete();
		#1;                                  // Back to drive point
	endtask

	// FIFO models and event counters
	always @(posedge system_clk)
	begin
		if (tx_fifo_wr_req)
		begin
			tx_cap.push_back(tx_fifo_wr_data);
			if (tx_fifo_full)
				full_writes++;
		end
		if (proc_irq)
			irq_count++;
		rx_pop = rx_fifo_rd_req;
		#2;
		if (rx_pop && rx_q.size() > 0)
			void'(rx_q.pop_front());         // Show-ahead pop
		rng_full        = xorshift32(rng_full);
		tx_fifo_full    = (rng_full[1:0] == 2'b00);  // Full about a quarter of the time
		rx_fifo_empty   = (rx_q.size() == 0);
		rx_fifo_rd_data = rx_fifo_empty ? '0 : rx_q[0];
	end

	initial
	begin
		int failed;
		int total;
		system_clk      = 1'b0;
		rst_n           = 1'b0;
		round_enable    = 1'b0;
		rx_fifo_empty   = 1'b1;
		rx_fifo_rd_data = '0;
		tx_fifo_full    = 1'b0;
		proc_out        = '0;
		rng_data        = 32'hf00aec93;
		rng_full        = xorshift32(32'hf00aec93);
		irq_count       = 0;
		full_writes     = 0;
		failed          = 0;
		total           = 0;
		for (int t = 0; t < NUM_TESTS; t++)
			test_err[t] = 0;
		for (int a = 0; a < gm_pkg::BUF_WORDS; a++)
			model[a] = '0;

		repeat (4) @(posedge system_clk);
		#2 rst_n = 1'b1;
		@(posedge system_clk);
		if (proc_irq || proc_in.request || proc_in.data_valid)
			report_error(T_RESET, "processor outputs not low after reset");
		if (rx_fifo_rd_req || tx_fifo_wr_req)
			report_error(T_RESET, "FIFO strobes not low after reset");
		if (!DUT.tx_ready)
			report_error(T_RESET, "tx_ready not high after reset");
		end_test(T_RESET);

		#2;
		for (int s = 0; s < 4; s++)
			push_packet(s);
		wait_level(2, 1'b0, "receive FIFO to show the packets");
		wait_level(2, 1'b1, "receive FIFO to drain");
		#2 round_enable = 1'b1;

		run_round(1, 1'b1);
		end_test(T_RX);
		check_transmit(T_WB);
		if (irq_count != 1)
			report_error(T_IRQ, $sformatf("%0d proc_irq pulses after round one", irq_count));
		end_test(T_WB);

		run_round(2, 1'b0);
		end_test(T_HOLD);
		check_transmit(T_BP);
		if (irq_count != 2)
			report_error(T_IRQ, $sformatf("%0d proc_irq pulses after round two", irq_count));
		if (full_writes != 0)
			report_error(T_BP, $sformatf("%0d writes while full", full_writes));
		end_test(T_IRQ);
		end_test(T_BP);

		for (int t = 0; t < NUM_TESTS; t++)
		begin
			total = total + test_err[t];
			if (test_err[t] != 0)
				failed++;
		end
		$display("Tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, failed, total);
		if (total == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== hdl/buffer_arbiter.sv ====
// Packet buffer owner selection
`timescale 1ns/1ps

module buffer_arbiter (
	input  logic             system_clk,
	input  logic             rst_n,
	input  logic             tx_req,
	input  logic             rx_req,
	input  logic             rd_req,
	input  logic             wr_req,
	input  gm_pkg::buf_req_t tx_acc,
	input  gm_pkg::buf_req_t rx_acc,
	input  gm_pkg::buf_req_t rd_acc,
	input  gm_pkg::buf_req_t wr_acc,
	output logic             tx_grant,
	output logic             rx_grant,
	output logic             rd_grant,
	output logic             wr_grant,
	output gm_pkg::buf_req_t buf_req
);

	gm_pkg::owner_t owner;
	logic           holding;                  // Current owner still asking

	always_comb
	begin
		holding = 1'b0;
		buf_req = '0;                         // Idle access, no write
		case (owner)
			gm_pkg::OWN_TX:
			begin
				holding = tx_req;
				buf_req = tx_acc;
			end
			gm_pkg::OWN_RX:
			begin
				holding = rx_req;
				buf_req = rx_acc;
			end
			gm_pkg::OWN_PROC_READ:
			begin
				holding = rd_req;
				buf_req = rd_acc;
			end
			gm_pkg::OWN_PROC_WRITE:
			begin
				holding = wr_req;
				buf_req = wr_acc;
			end
			default:
			begin
				holding = 1'b0;
			end
		endcase
	end

	// Owner keeps the buffer until it lets go, then priority tx, rx, rd, wr
	always_ff @(posedge system_clk or negedge rst_n)
	begin
		if (!rst_n)
			owner <= gm_pkg::OWN_IDLE;
		else if (!holding)
		begin
			if (tx_req)
				owner <= gm_pkg::OWN_TX;
			else if (rx_req)
				owner <= gm_pkg::OWN_RX;
			else if (rd_req)
				owner <= gm_pkg::OWN_PROC_READ;
			else if (wr_req)
				owner <= gm_pkg::OWN_PROC_WRITE;
			else
				owner <= gm_pkg::OWN_IDLE;
		end
	end

	assign tx_grant = (owner == gm_pkg::OWN_TX);
	assign rx_grant = (owner == gm_pkg::OWN_RX);
	assign rd_grant = (owner == gm_pkg::OWN_PROC_READ);
	assign wr_grant = (owner == gm_pkg::OWN_PROC_WRITE);

	// Writes only from an owner that still asks, never while idle
	a_write_from_owner: assert property (@(posedge system_clk) disable iff (!rst_n)
		buf_req.wren |-> holding);

endmodule

// ==== hdl/exchange_sequencer.sv ====
// Round sequencer for processor and players
`timescale 1ns/1ps

module exchange_sequencer #(
	parameter int ROUND_CYCLES = 50000000,
	parameter int NUM_PLAYERS  = 2
) (
	input  logic              system_clk,
	input  logic              rst_n,
	input  logic              round_enable,
	input  logic              rx_idle,
	output logic              proc_hold,
	output logic              proc_irq,
	output gm_pkg::proc_in_t  proc_in,
	input  gm_pkg::proc_out_t proc_out,
	output logic              rd_req,
	output logic              wr_req,
	input  logic              rd_grant,
	input  logic              wr_grant,
	output gm_pkg::buf_req_t  rd_acc,
	output gm_pkg::buf_req_t  wr_acc,
	input  gm_pkg::word_t     buf_q,
	output logic              tx_start,
	output gm_pkg::slot_t     tx_player,
	input  logic              tx_ready
);

	typedef enum logic [3:0] {
		S_IDLE, S_COUNT, S_IRQ,
		S_REQ, S_ACK_LOW, S_LOAD, S_WAIT_ACK,
		S_RECV, S_WAIT_LOW, S_WRITE,
		S_TX_WAIT, S_TX_FALL, S_TX_RISE
	} seq_state_t;

	localparam int                TW          = $clog2(ROUND_CYCLES + 1);
	localparam logic [TW-1:0]     TIMER_MAX   = TW'(ROUND_CYCLES);
	localparam gm_pkg::buf_addr_t RD_FIRST    = gm_pkg::buf_addr_t'(gm_pkg::RX_BASE);
	localparam gm_pkg::slot_t     LAST_PLAYER = gm_pkg::slot_t'(NUM_PLAYERS - 1);

	seq_state_t        state;
	logic [TW-1:0]     timer;                  // Cycles since back to idle
	gm_pkg::buf_addr_t rd_ptr;                 // Read-out address, 256..511
	gm_pkg::buf_addr_t wr_ptr;                 // Write-back address from 0
	gm_pkg::word_t     wb_data;                // Latched write-back word
	gm_pkg::slot_t     player;

	assign proc_hold = (state != S_IDLE) && (state != S_COUNT);
	assign proc_irq  = (state == S_IRQ);       // Single cycle pulse
	assign rd_req    = (state inside {S_REQ, S_ACK_LOW, S_LOAD, S_WAIT_ACK});
	assign wr_req    = (state inside {S_RECV, S_WAIT_LOW, S_WRITE});
	assign rd_acc    = '{addr: rd_ptr, data: '0, wren: 1'b0};
	assign wr_acc    = '{addr: wr_ptr, data: wb_data, wren: (state == S_WRITE) && wr_grant};
	assign tx_start  = (state == S_TX_WAIT) && tx_ready;
	assign tx_player = player;

	always_ff @(posedge system_clk)
	begin
		if ((state == S_RECV) && proc_out.data_ready)
			wb_data <= proc_out.data;
	end

	always_ff @(posedge system_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= S_IDLE;
			timer   <= '0;
			rd_ptr  <= RD_FIRST;
			wr_ptr  <= '0;
			player  <= '0;
			proc_in <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					timer <= '0;
					state <= S_COUNT;
				end
				S_COUNT:
				begin
					rd_ptr <= RD_FIRST;
					if (timer != TIMER_MAX)
						timer <= timer + 1'b1;  // Saturates at round length
					else if (round_enable && rx_idle)
						state <= S_IRQ;         // Round starts, buffer held
				end
				S_IRQ:
				begin
					proc_in.request <= 1'b1;
					state           <= S_REQ;
				end
				S_REQ:
				begin
					if (proc_out.rdy_read)
					begin
						proc_in.request <= 1'b0;
						state           <= S_ACK_LOW;
					end
				end
				S_ACK_LOW:
				begin
					if (!proc_out.ack && rd_grant)
						state <= S_LOAD;        // Address rd_ptr read this cycle
				end
				S_LOAD:
				begin
					proc_in.data       <= buf_q;
					proc_in.data_valid <= 1'b1;
					rd_ptr             <= (rd_ptr == '1) ? RD_FIRST : rd_ptr + 1'b1;
					state              <= S_WAIT_ACK;
				end
				S_WAIT_ACK:
				begin
					if (proc_out.ack)
					begin
						proc_in.data_valid <= 1'b0;
						if (rd_ptr == RD_FIRST)
						begin
							wr_ptr <= '0;        // Wrapped, read-out complete
							state  <= S_RECV;
						end
						else
							state <= S_ACK_LOW;
					end
				end
				S_RECV:
				begin
					if (proc_out.done)
					begin
						player <= '0;
						state  <= S_TX_WAIT;
					end
					else if (proc_out.data_ready)
						state <= S_WAIT_LOW;
				end
				S_WAIT_LOW:
				begin
					if (!proc_out.data_ready)
						state <= S_WRITE;
				end
				S_WRITE:
				begin
					if (wr_grant)
					begin
						wr_ptr <= wr_ptr + 1'b1;
						state  <= S_RECV;
					end
				end
				S_TX_WAIT:
				begin
					if (tx_ready)
						state <= S_TX_FALL;     // tx_start pulsed here
				end
				S_TX_FALL:
				begin
					if (!tx_ready)
						state <= S_TX_RISE;
				end
				S_TX_RISE:
				begin
					if (tx_ready)
					begin
						if (player == LAST_PLAYER)
							state <= S_IDLE;
						else
						begin
							player <= player + 1'b1;
							state  <= S_TX_WAIT;
						end
					end
				end
				default:
				begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	a_valid_not_request: assert property (@(posedge system_clk) disable iff (!rst_n)
		!(proc_in.request && proc_in.data_valid));

endmodule

// ==== hdl/gm_controller.sv ====
// Game master packet hub
`timescale 1ns/1ps

module gm_controller #(
	parameter int ROUND_CYCLES = 50000000,
	parameter int NUM_PLAYERS  = 2
) (
	input  logic              system_clk,
	input  logic              rst_n,
	input  logic              round_enable,
	input  logic              rx_fifo_empty,     // Show-ahead receive FIFO
	input  gm_pkg::word_t     rx_fifo_rd_data,
	output logic              rx_fifo_rd_req,
	input  logic              tx_fifo_full,      // Transmit FIFO write port
	output logic              tx_fifo_wr_req,
	output gm_pkg::word_t     tx_fifo_wr_data,
	output logic              proc_irq,          // Processor port
	output gm_pkg::proc_in_t  proc_in,
	input  gm_pkg::proc_out_t proc_out
);

	gm_pkg::buf_req_t buf_req;
	gm_pkg::word_t    buf_q;
	gm_pkg::buf_req_t tx_acc;
	gm_pkg::buf_req_t rx_acc;
	gm_pkg::buf_req_t rd_acc;
	gm_pkg::buf_req_t wr_acc;
	logic             tx_req;
	logic             rx_req;
	logic             rd_req;
	logic             wr_req;
	logic             tx_grant;
	logic             rx_grant;
	logic             rd_grant;
	logic             wr_grant;
	logic             rx_idle;
	logic             proc_hold;
	logic             tx_start;
	gm_pkg::slot_t    tx_player;
	logic             tx_ready;

	packet_buffer u_buffer (
		.system_clk (system_clk),
		.buf_req    (buf_req),
		.buf_q      (buf_q)
	);

	buffer_arbiter u_arbiter (
		.system_clk (system_clk),
		.rst_n      (rst_n),
		.tx_req     (tx_req),
		.rx_req     (rx_req),
		.rd_req     (rd_req),
		.wr_req     (wr_req),
		.tx_acc     (tx_acc),
		.rx_acc     (rx_acc),
		.rd_acc     (rd_acc),
		.wr_acc     (wr_acc),
		.tx_grant   (tx_grant),
		.rx_grant   (rx_grant),
		.rd_grant   (rd_grant),
		.wr_grant   (wr_grant),
		.buf_req    (buf_req)
	);

	rx_packet_writer u_rx (
		.system_clk      (system_clk),
		.rst_n           (rst_n),
		.rx_fifo_empty   (rx_fifo_empty),
		.rx_fifo_rd_data (rx_fifo_rd_data),
		.rx_fifo_rd_req  (rx_fifo_rd_req),
		.proc_hold       (proc_hold),
		.rx_idle         (rx_idle),
		.bus_req         (rx_req),
		.bus_grant       (rx_grant),
		.bus_acc         (rx_acc)
	);

	tx_packet_reader #(
		.NUM_PLAYERS (NUM_PLAYERS)
	) u_tx (
		.system_clk      (system_clk),
		.rst_n           (rst_n),
		.tx_start        (tx_start),
		.tx_player       (tx_player),
		.tx_ready        (tx_ready),
		.bus_req         (tx_req),
		.bus_grant       (tx_grant),
		.bus_acc         (tx_acc),
		.buf_q           (buf_q),
		.tx_fifo_full    (tx_fifo_full),
		.tx_fifo_wr_req  (tx_fifo_wr_req),
		.tx_fifo_wr_data (tx_fifo_wr_data)
	);

	exchange_sequencer #(
		.ROUND_CYCLES (ROUND_CYCLES),
		.NUM_PLAYERS  (NUM_PLAYERS)
	) u_seq (
		.system_clk   (system_clk),
		.rst_n        (rst_n),
		.round_enable (round_enable),
		.rx_idle      (rx_idle),
		.proc_hold    (proc_hold),
		.proc_irq     (proc_irq),
		.proc_in      (proc_in),
		.proc_out     (proc_out),
		.rd_req       (rd_req),
		.wr_req       (wr_req),
		.rd_grant     (rd_grant),
		.wr_grant     (wr_grant),
		.rd_acc       (rd_acc),
		.wr_acc       (wr_acc),
		.buf_q        (buf_q),
		.tx_start     (tx_start),
		.tx_player    (tx_player),
		.tx_ready     (tx_ready)
	);

endmodule

// ==== hdl/gm_pkg.sv ====
// Packet hub shared definitions
package gm_pkg;

	typedef logic [15:0] word_t;        // Buffer and FIFO word
	typedef logic [8:0]  buf_addr_t;    // Packet buffer address
	typedef logic [1:0]  slot_t;        // Player slot index

	localparam int BUF_WORDS  = 512;    // Buffer depth
	localparam int SLOT_WORDS = 64;     // One player block
	localparam int RX_BASE    = 256;    // Start of received-data half

	// One client's view of the buffer port
	typedef struct packed {
		buf_addr_t addr;
		word_t     data;
		logic      wren;
	} buf_req_t;

	// Hub to processor
	typedef struct packed {
		logic  request;                 // Start of read-out
		logic  data_valid;              // Word on data
		word_t data;
	} proc_in_t;

	// Processor to hub
	typedef struct packed {
		logic  ack;                     // Word taken
		logic  rdy_read;                // Ready for read-out
		logic  data_ready;              // Write-back word on data
		logic  done;                    // Write-back finished
		word_t data;
	} proc_out_t;

	typedef enum logic [2:0] {
		OWN_IDLE,
		OWN_TX,
		OWN_RX,
		OWN_PROC_READ,
		OWN_PROC_WRITE
	} owner_t;

endpackage

// ==== hdl/packet_buffer.sv ====
// Shared packet buffer
`timescale 1ns/1ps

module packet_buffer (
	input  logic             system_clk,
	input  gm_pkg::buf_req_t buf_req,
	output gm_pkg::word_t    buf_q
);

	gm_pkg::word_t mem [gm_pkg::BUF_WORDS];   // 512 x 16 storage

	// Single port, read registered every cycle
	always_ff @(posedge system_clk)
	begin
		if (buf_req.wren)
			mem[buf_req.addr] <= buf_req.data;
		buf_q <= mem[buf_req.addr];           // Old data on a write cycle
	end

endmodule

// ==== hdl/rx_packet_writer.sv ====
// Received packet to buffer copier
`timescale 1ns/1ps

module rx_packet_writer (
	input  logic             system_clk,
	input  logic             rst_n,
	input  logic             rx_fifo_empty,
	input  gm_pkg::word_t    rx_fifo_rd_data,
	output logic             rx_fifo_rd_req,
	input  logic             proc_hold,
	output logic             rx_idle,
	output logic             bus_req,
	input  logic             bus_grant,
	output gm_pkg::buf_req_t bus_acc
);

	typedef enum logic {R_IDLE, R_MOVE} rx_state_t;

	rx_state_t         state;
	logic [6:0]        left;                   // Payload words still to copy
	gm_pkg::buf_addr_t wr_addr;                // Next slot address
	gm_pkg::slot_t     hdr_slot;
	logic [6:0]        hdr_count;
	logic              take_hdr;
	logic              take_word;

	assign hdr_slot  = rx_fifo_rd_data[1:0];   // Header layout
	assign hdr_count = rx_fifo_rd_data[14:8];

	// No new packet starts while a round holds the buffer
	assign take_hdr  = (state == R_IDLE) && !rx_fifo_empty && !proc_hold;
	assign take_word = (state == R_MOVE) && bus_grant && !rx_fifo_empty;

	assign rx_fifo_rd_req = take_hdr || take_word;
	assign rx_idle        = (state == R_IDLE) && rx_fifo_empty;
	assign bus_req        = (state == R_MOVE);
	assign bus_acc        = '{addr: wr_addr, data: rx_fifo_rd_data, wren: take_word};

	always_ff @(posedge system_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= R_IDLE;
			left    <= '0;
			wr_addr <= '0;
		end
		else
		begin
			case (state)
				R_IDLE:
				begin
					if (take_hdr)
					begin
						left    <= hdr_count;
						wr_addr <= gm_pkg::buf_addr_t'(gm_pkg::RX_BASE
							+ int'(hdr_slot) * gm_pkg::SLOT_WORDS);
						if (hdr_count != '0)
							state <= R_MOVE;     // Empty packet is dropped
					end
				end
				R_MOVE:
				begin
					if (take_word)             // Stalls on empty or no grant
					begin
						wr_addr <= wr_addr + 1'b1;
						left    <= left - 1'b1;
						if (left == 7'd1)
							state <= R_IDLE;   // Last word, release bus
					end
				end
				default:
				begin
					state <= R_IDLE;
				end
			endcase
		end
	end

	// Payload stays in the received half
	a_write_in_rx_half: assert property (@(posedge system_clk) disable iff (!rst_n)
		bus_acc.wren |-> (bus_acc.addr >= gm_pkg::buf_addr_t'(gm_pkg::RX_BASE)));

endmodule

// ==== hdl/tx_packet_reader.sv ====
// Player block to transmit FIFO
`timescale 1ns/1ps

module tx_packet_reader #(
	parameter int NUM_PLAYERS = 2
) (
	input  logic             system_clk,
	input  logic             rst_n,
	input  logic             tx_start,
	input  gm_pkg::slot_t    tx_player,
	output logic             tx_ready,
	output logic             bus_req,
	input  logic             bus_grant,
	output gm_pkg::buf_req_t bus_acc,
	input  gm_pkg::word_t    buf_q,
	input  logic             tx_fifo_full,
	output logic             tx_fifo_wr_req,
	output gm_pkg::word_t    tx_fifo_wr_data
);

	typedef enum logic [1:0] {T_IDLE, T_HDR, T_DATA} tx_state_t;

	localparam logic [5:0] LAST_WORD = 6'(gm_pkg::SLOT_WORDS - 1);

	tx_state_t         state;
	gm_pkg::slot_t     player;                 // Latched destination
	logic [5:0]        cur;                    // Block word held in buf_q
	logic              q_valid;                // buf_q holds word cur
	logic              fire;                   // Data word goes out
	gm_pkg::buf_addr_t base;

	assign base = gm_pkg::buf_addr_t'(int'(player) * gm_pkg::SLOT_WORDS);
	assign fire = (state == T_DATA) && q_valid && !tx_fifo_full;

	// Read ahead by one word when sending, else keep address to hold buf_q
	assign bus_acc = '{
		addr: base + gm_pkg::buf_addr_t'(cur) + gm_pkg::buf_addr_t'(fire),
		data: '0,
		wren: 1'b0
	};

	assign tx_ready        = (state == T_IDLE);
	assign bus_req         = (state != T_IDLE);
	assign tx_fifo_wr_req  = ((state == T_HDR) && !tx_fifo_full) || fire;
	assign tx_fifo_wr_data = (state == T_HDR) ? gm_pkg::word_t'(player) + 16'd1 : buf_q;

	always_ff @(posedge system_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= T_IDLE;
			player  <= '0;
			cur     <= '0;
			q_valid <= 1'b0;
		end
		else
		begin
			q_valid <= (state == T_DATA) && bus_grant;  // One cycle read latency
			case (state)
				T_IDLE:
				begin
					if (tx_start)
					begin
						player <= tx_player;
						cur    <= '0;
						state  <= T_HDR;
					end
				end
				T_HDR:
				begin
					if (!tx_fifo_full)
						state <= T_DATA;       // Header written
				end
				T_DATA:
				begin
					if (fire)
					begin
						cur <= cur + 1'b1;
						if (cur == LAST_WORD)
							state <= T_IDLE;
					end
				end
				default:
				begin
					state <= T_IDLE;
				end
			endcase
		end
	end

	// Buffer stays owned while block words go out
	a_owned_while_sending: assert property (@(posedge system_clk) disable iff (!rst_n)
		fire |-> bus_grant);

	// Sequencer only asks for configured players
	a_player_range: assert property (@(posedge system_clk) disable iff (!rst_n)
		tx_start |-> (int'(tx_player) < NUM_PLAYERS));

endmodule

// ==== project.f ====
hdl/gm_pkg.sv
hdl/packet_buffer.sv
hdl/buffer_arbiter.sv
hdl/rx_packet_writer.sv
hdl/tx_packet_reader.sv
hdl/exchange_sequencer.sv
hdl/gm_controller.sv
dv/tb_gm_controller.sv
